// ==== source/sys_pkg.sv ====
// system unit shared definitions
package sys_pkg;

  // architectural widths
  localparam int XLEN   = 64;
  localparam int ILEN   = 32;
  localparam int CSR_AW = 12;

  typedef logic [XLEN-1:0]   xlen_t;
  typedef logic [CSR_AW-1:0] csr_addr_t;
  typedef logic [ILEN-1:0]   instr_t;

  // machine csr addresses
  localparam csr_addr_t CSR_MSTATUS = 12'h300;
  localparam csr_addr_t CSR_MTVEC   = 12'h305;
  localparam csr_addr_t CSR_MEPC    = 12'h341;
  localparam csr_addr_t CSR_MCAUSE  = 12'h342;

  localparam xlen_t MSTATUS_RESET = 64'ha00001800; // uxl/sxl = 64 bit, mpp = m
  localparam xlen_t RESET_PC      = 64'h80000000;
  localparam xlen_t CAUSE_ECALL_M = 64'd11;

  localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

  // funct3 of the system opcode
  localparam logic [2:0] F3_PRIV   = 3'b000;
  localparam logic [2:0] F3_CSRRW  = 3'b001;
  localparam logic [2:0] F3_CSRRS  = 3'b010;
  localparam logic [2:0] F3_CSRRC  = 3'b011;
  localparam logic [2:0] F3_CSRRWI = 3'b101;
  localparam logic [2:0] F3_CSRRSI = 3'b110;
  localparam logic [2:0] F3_CSRRCI = 3'b111;

  // fixed privileged encodings
  localparam instr_t INSTR_ECALL = 32'h00000073;
  localparam instr_t INSTR_MRET  = 32'h30200073;

  typedef enum logic [2:0] {
    OP_NONE,
    OP_CSRRW,
    OP_CSRRS,
    OP_CSRRC,
    OP_ECALL,
    OP_MRET
  } csr_op_e;

endpackage

// ==== source/sys_decoder.sv ====
// system instruction decoder
`timescale 1ns/1ns

module sys_decoder (
  input  sys_pkg::instr_t    i_instr,
  input  logic               i_instr_valid,
  input  sys_pkg::xlen_t     i_rs1_data,
  output sys_pkg::csr_op_e   o_op,
  output sys_pkg::csr_addr_t o_csr_addr,
  output sys_pkg::xlen_t     o_wdata,
  output logic               o_csr_wr,
  output logic               o_rd_we
);
  import sys_pkg::*;

  logic [6:0] opcode;
  logic [4:0] rd;
  logic [2:0] funct3;
  logic [4:0] rs1;
  logic       is_system;
  logic       is_csr;
  logic       use_imm;
  csr_op_e    op;

  assign opcode    = i_instr[6:0];
  assign rd        = i_instr[11:7];
  assign funct3    = i_instr[14:12];
  assign rs1       = i_instr[19:15];
  assign is_system = i_instr_valid && (opcode == OPC_SYSTEM);

  always_comb begin
    op      = OP_NONE;
    use_imm = 1'b0;
    if (is_system) begin
      case (funct3)
        F3_CSRRW:  op = OP_CSRRW;
        F3_CSRRS:  op = OP_CSRRS;
        F3_CSRRC:  op = OP_CSRRC;
        F3_CSRRWI: begin
          op      = OP_CSRRW;
          use_imm = 1'b1;
        end
        F3_CSRRSI: begin
          op      = OP_CSRRS;
          use_imm = 1'b1;
        end
        F3_CSRRCI: begin
          op      = OP_CSRRC;
          use_imm = 1'b1;
        end
        F3_PRIV: begin
          // whole word must match, other priv forms fall through
          if (i_instr == INSTR_ECALL) begin
            op = OP_ECALL;
          end else if (i_instr == INSTR_MRET) begin
            op = OP_MRET;
          end
        end
        default: ; // funct3 100 reserved
      endcase
    end
  end

  assign is_csr = (op == OP_CSRRW) || (op == OP_CSRRS) || (op == OP_CSRRC);

  assign o_op       = op;
  assign o_csr_addr = i_instr[31:20];

  // rs1 field doubles as uimm for i-forms
  assign o_wdata = use_imm ? {{(XLEN-5){1'b0}}, rs1} : i_rs1_data;

  // set/clear with x0 or zero uimm is a pure read
  assign o_csr_wr = is_csr && ((op == OP_CSRRW) || (rs1 != 5'd0));
  assign o_rd_we  = is_csr && (rd != 5'd0);

endmodule

// ==== source/csr_file.sv ====
// machine mode csr file
`timescale 1ns/1ns

module csr_file (
  input  logic               i_clk,
  input  logic               i_arst_n,
  input  sys_pkg::csr_op_e   i_op,
  input  sys_pkg::csr_addr_t i_csr_addr,
  input  sys_pkg::xlen_t     i_wdata,
  input  logic               i_csr_wr,
  input  sys_pkg::xlen_t     i_epc,
  output sys_pkg::xlen_t     o_rdata,
  output logic               o_redirect,
  output sys_pkg::xlen_t     o_redirect_pc
);
  import sys_pkg::*;

  xlen_t mstatus;
  xlen_t mtvec;
  xlen_t mepc;
  xlen_t mcause;
  xlen_t rdata;
  xlen_t wdata_new;
  logic  is_csr;
  logic  csr_we;

  assign is_csr = (i_op == OP_CSRRW) || (i_op == OP_CSRRS) || (i_op == OP_CSRRC);
  assign csr_we = is_csr && i_csr_wr;

  // read mux, unknown address reads zero
  always_comb begin
    case (i_csr_addr)
      CSR_MSTATUS: rdata = mstatus;
      CSR_MTVEC:   rdata = mtvec;
      CSR_MEPC:    rdata = mepc;
      CSR_MCAUSE:  rdata = mcause;
      default:     rdata = '0;
    endcase
  end

  // old value goes to rd
  assign o_rdata = is_csr ? rdata : '0;

  // read-modify-write value
  always_comb begin
    case (i_op)
      OP_CSRRS: wdata_new = rdata | i_wdata;
      OP_CSRRC: wdata_new = rdata & ~i_wdata;
      default:  wdata_new = i_wdata;
    endcase
  end

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      mstatus <= MSTATUS_RESET;
      mtvec   <= '0;
      mepc    <= '0;
      mcause  <= '0;
    end else if (i_op == OP_ECALL) begin
      mepc   <= i_epc; // pc of the ecall itself
      mcause <= CAUSE_ECALL_M;
    end else if (csr_we) begin
      case (i_csr_addr)
        CSR_MSTATUS: mstatus <= wdata_new;
        CSR_MTVEC:   mtvec   <= wdata_new;
        CSR_MEPC:    mepc    <= wdata_new;
        CSR_MCAUSE:  mcause  <= wdata_new;
        default: ; // unknown address, write dropped
      endcase
    end
  end

  // trap entry and return targets
  always_comb begin
    o_redirect    = 1'b0;
    o_redirect_pc = '0;
    case (i_op)
      OP_ECALL: begin
        o_redirect    = 1'b1;
        o_redirect_pc = {mtvec[XLEN-1:2], 2'b00}; // direct mode only
      end
      OP_MRET: begin
        o_redirect    = 1'b1;
        o_redirect_pc = {mepc[XLEN-1:2], 2'b00}; // ialign 32
      end
      default: ;
    endcase
  end

endmodule

// ==== source/pc_sequencer.sv ====
// program counter sequencer
`timescale 1ns/1ns

module pc_sequencer (
  input  logic           i_clk,
  input  logic           i_arst_n,
  input  logic           i_step,
  input  logic           i_redirect,
  input  sys_pkg::xlen_t i_redirect_pc,
  output sys_pkg::xlen_t o_pc
);
  import sys_pkg::*;

  xlen_t pc_q;
  xlen_t pc_next;

  // trap/return target wins over sequential step
  assign pc_next = i_redirect ? i_redirect_pc : pc_q + xlen_t'(4);

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      pc_q <= RESET_PC;
    end else if (i_step) begin
      pc_q <= pc_next;
    end
  end

  assign o_pc = pc_q;

endmodule

// ==== source/sys_unit_top.sv ====
// system unit top level
`timescale 1ns/1ns

module sys_unit_top (
  input  logic            i_clk,
  input  logic            i_arst_n,
  input  sys_pkg::instr_t i_instr,
  input  logic            i_instr_valid,
  input  sys_pkg::xlen_t  i_rs1_data,
  output sys_pkg::xlen_t  o_rd_data,
  output logic            o_rd_we,
  output sys_pkg::xlen_t  o_pc,
  output logic            o_redirect
);
  import sys_pkg::*;

  csr_op_e   d_op;
  csr_addr_t d_csr_addr;
  xlen_t     d_wdata;
  logic      d_csr_wr;
  logic      redirect;
  xlen_t     redirect_pc;
  xlen_t     cur_pc;

  sys_decoder u_decoder (
    .i_instr       (i_instr),
    .i_instr_valid (i_instr_valid),
    .i_rs1_data    (i_rs1_data),
    .o_op          (d_op),
    .o_csr_addr    (d_csr_addr),
    .o_wdata       (d_wdata),
    .o_csr_wr      (d_csr_wr),
    .o_rd_we       (o_rd_we)
  );

  csr_file u_csr_file (
    .i_clk         (i_clk),
    .i_arst_n      (i_arst_n),
    .i_op          (d_op),
    .i_csr_addr    (d_csr_addr),
    .i_wdata       (d_wdata),
    .i_csr_wr      (d_csr_wr),
    .i_epc         (cur_pc),
    .o_rdata       (o_rd_data),
    .o_redirect    (redirect),
    .o_redirect_pc (redirect_pc)
  );

  pc_sequencer u_pc_sequencer (
    .i_clk         (i_clk),
    .i_arst_n      (i_arst_n),
    .i_step        (i_instr_valid),
    .i_redirect    (redirect),
    .i_redirect_pc (redirect_pc),
    .o_pc          (cur_pc)
  );

  assign o_pc       = cur_pc;
  assign o_redirect = redirect;

endmodule

// ==== dv/sys_unit_properties.sv ====
// system unit assertions
`timescale 1ns/1ns

module sys_unit_properties (
  input logic           i_clk,
  input logic           i_arst_n,
  input logic           i_instr_valid,
  input logic           i_rd_we,
  input logic           i_redirect,
  input sys_pkg::xlen_t i_pc
);

  // trap or return only for a strobed instruction
  a_redirect_needs_valid : assert property (
    @(posedge i_clk) disable iff (!i_arst_n)
    i_redirect |-> i_instr_valid
  ) else $error("redirect raised without a valid instruction");

  a_rd_we_needs_valid : assert property (
    @(posedge i_clk) disable iff (!i_arst_n)
    i_rd_we |-> i_instr_valid
  ) else $error("rd write enable raised without a valid instruction");

  // ialign 32
  a_pc_word_aligned : assert property (
    @(posedge i_clk) disable iff (!i_arst_n)
    i_pc[1:0] == 2'b00
  ) else $error("program counter is not word aligned");

  // no strobe, no pc movement
  a_pc_holds_when_idle : assert property (
    @(posedge i_clk) disable iff (!i_arst_n)
    !i_instr_valid |=> $stable(i_pc)
  ) else $error("program counter moved without a valid instruction");

endmodule

// ==== dv/sys_unit_tb.sv ====
// system unit testbench
`timescale 1ns/1ns

module sys_unit_tb;
  import sys_pkg::*;

  localparam int RESET_CYCLES  = 10;
  localparam int RESET_TIMEOUT = 100;
  localparam int IDLE_CYCLES   = 4;

  logic   i_clk;
  logic   i_arst_n;
  instr_t i_instr;
  logic   i_instr_valid;
  xlen_t  i_rs1_data;
  xlen_t  o_rd_data;
  logic   o_rd_we;
  xlen_t  o_pc;
  logic   o_redirect;

  // stimulus table, one entry per instruction
  string  t_name[$];
  instr_t t_instr[$];
  xlen_t  t_rs1[$];
  xlen_t  t_rd_data[$];
  logic   t_rd_we[$];
  logic   t_redirect[$];
  xlen_t  t_pc[$];

  sys_unit_top UUT (
    .i_clk         (i_clk),
    .i_arst_n      (i_arst_n),
    .i_instr       (i_instr),
    .i_instr_valid (i_instr_valid),
    .i_rs1_data    (i_rs1_data),
    .o_rd_data     (o_rd_data),
    .o_rd_we       (o_rd_we),
    .o_pc          (o_pc),
    .o_redirect    (o_redirect)
  );

  bind sys_unit_top sys_unit_properties u_properties (
    .i_clk         (i_clk),
    .i_arst_n      (i_arst_n),
    .i_instr_valid (i_instr_valid),
    .i_rd_we       (o_rd_we),
    .i_redirect    (o_redirect),
    .i_pc          (o_pc)
  );

  initial begin
    i_clk = 1'b0;
    forever #5 i_clk = ~i_clk;
  end

  initial begin
    i_arst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge i_clk);
    i_arst_n <= 1'b1;
  end

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("Result: FAILED");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_data(input string name, input xlen_t exp, input xlen_t act);
    if (act !== exp) begin
      stop_on_error($sformatf("FAILED %s: expected %h, actual %h", name, exp, act));
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      stop_on_error($sformatf("FAILED %s: expected %b, actual %b", name, exp, act));
    end
  endtask

  task automatic check_op_pc(input string name, input xlen_t exp, input xlen_t act);
    if (act !== exp) begin
      stop_on_error($sformatf("FAILED %s: expected pc %h, actual pc %h", name, exp, act));
    end
  endtask

  // i-type system encoding
  function automatic instr_t csr_instr(input logic [2:0] f3, input csr_addr_t csr,
                                       input logic [4:0] rs1, input logic [4:0] rd);
    return {csr, rs1, f3, rd, OPC_SYSTEM};
  endfunction

  task automatic add_row(input string name, input instr_t instr, input xlen_t rs1,
                         input xlen_t rd_data, input logic rd_we, input logic redirect,
                         input xlen_t pc);
    t_name.push_back(name);
    t_instr.push_back(instr);
    t_rs1.push_back(rs1);
    t_rd_data.push_back(rd_data);
    t_rd_we.push_back(rd_we);
    t_redirect.push_back(redirect);
    t_pc.push_back(pc);
  endtask

  task automatic build_table;
    // reset values, rs1 = x0 so no write despite the data
    add_row("rst mstatus", csr_instr(F3_CSRRS, CSR_MSTATUS, 5'd0, 5'd5),
            64'hffff_ffff_ffff_ffff, 64'h0000_000a_0000_1800, 1'b1, 1'b0, 64'h8000_0004);
    add_row("rst mtvec", csr_instr(F3_CSRRS, CSR_MTVEC, 5'd0, 5'd5),
            64'hffff_ffff_ffff_ffff, 64'h0, 1'b1, 1'b0, 64'h8000_0008);
    add_row("rst mepc", csr_instr(F3_CSRRS, CSR_MEPC, 5'd0, 5'd5),
            64'hffff_ffff_ffff_ffff, 64'h0, 1'b1, 1'b0, 64'h8000_000c);
    add_row("rst mcause", csr_instr(F3_CSRRS, CSR_MCAUSE, 5'd0, 5'd5),
            64'hffff_ffff_ffff_ffff, 64'h0, 1'b1, 1'b0, 64'h8000_0010);
    add_row("mstatus no write", csr_instr(F3_CSRRS, CSR_MSTATUS, 5'd0, 5'd5),
            64'hffff_ffff_ffff_ffff, 64'h0000_000a_0000_1800, 1'b1, 1'b0, 64'h8000_0014);
    // swap into mtvec
    add_row("csrrw mtvec", csr_instr(F3_CSRRW, CSR_MTVEC, 5'd1, 5'd6),
            64'h0000_0000_8000_0103, 64'h0, 1'b1, 1'b0, 64'h8000_0018);
    add_row("mtvec readback", csr_instr(F3_CSRRS, CSR_MTVEC, 5'd0, 5'd6),
            64'h0, 64'h0000_0000_8000_0103, 1'b1, 1'b0, 64'h8000_001c);
    // set and clear on mepc
    add_row("csrrw mepc", csr_instr(F3_CSRRW, CSR_MEPC, 5'd2, 5'd7),
            64'h0000_0000_0000_00f0, 64'h0, 1'b1, 1'b0, 64'h8000_0020);
    add_row("csrrs mepc", csr_instr(F3_CSRRS, CSR_MEPC, 5'd3, 5'd7),
            64'h0000_0000_0000_0f00, 64'h0f0, 1'b1, 1'b0, 64'h8000_0024);
    add_row("csrrc mepc", csr_instr(F3_CSRRC, CSR_MEPC, 5'd4, 5'd7),
            64'h0000_0000_0000_0030, 64'hff0, 1'b1, 1'b0, 64'h8000_0028);
    add_row("csrrsi mepc", csr_instr(F3_CSRRSI, CSR_MEPC, 5'h0f, 5'd7),
            64'h0000_0000_dead_beef, 64'hfc0, 1'b1, 1'b0, 64'h8000_002c);
    add_row("csrrci mepc", csr_instr(F3_CSRRCI, CSR_MEPC, 5'h03, 5'd7),
            64'h0000_0000_dead_beef, 64'hfcf, 1'b1, 1'b0, 64'h8000_0030);
    add_row("mepc readback", csr_instr(F3_CSRRS, CSR_MEPC, 5'd0, 5'd7),
            64'h0, 64'hfcc, 1'b1, 1'b0, 64'h8000_0034);
    add_row("csrrsi zero uimm", csr_instr(F3_CSRRSI, CSR_MEPC, 5'd0, 5'd7),
            64'hffff_ffff_ffff_ffff, 64'hfcc, 1'b1, 1'b0, 64'h8000_0038);
    // trap to mtvec with low bits dropped
    add_row("ecall", 32'h0000_0073, 64'h0, 64'h0, 1'b0, 1'b1, 64'h8000_0100);
    add_row("mepc after ecall", csr_instr(F3_CSRRS, CSR_MEPC, 5'd0, 5'd8),
            64'h0, 64'h0000_0000_8000_0038, 1'b1, 1'b0, 64'h8000_0104);
    add_row("mcause after ecall", csr_instr(F3_CSRRS, CSR_MCAUSE, 5'd0, 5'd8),
            64'h0, 64'd11, 1'b1, 1'b0, 64'h8000_0108);
    add_row("mret", 32'h3020_0073, 64'h0, 64'h0, 1'b0, 1'b1, 64'h8000_0038);
    // unimplemented address 0x7c0
    add_row("unknown csr write", csr_instr(F3_CSRRW, 12'h7c0, 5'd1, 5'd9),
            64'hffff_ffff_ffff_ffff, 64'h0, 1'b1, 1'b0, 64'h8000_003c);
    add_row("unknown csr read", csr_instr(F3_CSRRS, 12'h7c0, 5'd0, 5'd9),
            64'h0, 64'h0, 1'b1, 1'b0, 64'h8000_0040);
    add_row("rd x0", csr_instr(F3_CSRRS, CSR_MEPC, 5'd0, 5'd0),
            64'h0, 64'h0000_0000_8000_0038, 1'b0, 1'b0, 64'h8000_0044);
    add_row("mtvec unchanged", csr_instr(F3_CSRRS, CSR_MTVEC, 5'd0, 5'd9),
            64'h0, 64'h0000_0000_8000_0103, 1'b1, 1'b0, 64'h8000_0048);
    add_row("mstatus unchanged", csr_instr(F3_CSRRS, CSR_MSTATUS, 5'd0, 5'd9),
            64'h0, 64'h0000_000a_0000_1800, 1'b1, 1'b0, 64'h8000_004c);
    add_row("mcause unchanged", csr_instr(F3_CSRRS, CSR_MCAUSE, 5'd0, 5'd9),
            64'h0, 64'd11, 1'b1, 1'b0, 64'h8000_0050);
    add_row("non system addi", 32'h0010_0093, 64'h0, 64'h0, 1'b0, 1'b0, 64'h8000_0054);
    // write still happens with rd = x0
    add_row("csrrw x0 mcause", csr_instr(F3_CSRRW, CSR_MCAUSE, 5'd1, 5'd0),
            64'h5, 64'd11, 1'b0, 1'b0, 64'h8000_0058);
    add_row("mcause written", csr_instr(F3_CSRRS, CSR_MCAUSE, 5'd0, 5'd10),
            64'h0, 64'h5, 1'b1, 1'b0, 64'h8000_005c);
  endtask

  task automatic wait_reset_release;
    int cycles;
    cycles = 0;
    while (i_arst_n !== 1'b1) begin
      @(posedge i_clk);
      cycles++;
      if (cycles > RESET_TIMEOUT) begin
        stop_on_error("reset was never released");
      end
    end
  endtask

  task automatic run_table;
    int last;
    last = t_name.size() - 1;
    for (int i = 0; i <= last; i++) begin
      @(posedge i_clk);
      i_instr       <= t_instr[i];
      i_rs1_data    <= t_rs1[i];
      i_instr_valid <= 1'b1;
      @(negedge i_clk);
      // pc from the previous row has landed by now
      if (i > 0) begin
        check_op_pc({t_name[i-1], " pc"}, t_pc[i-1], o_pc);
      end
      check_data({t_name[i], " rd_data"}, t_rd_data[i], o_rd_data);
      check_bit({t_name[i], " rd_we"}, t_rd_we[i], o_rd_we);
      check_bit({t_name[i], " redirect"}, t_redirect[i], o_redirect);
    end
    @(posedge i_clk);
    i_instr       <= 32'h0000_0073; // ecall on the bus without strobe
    i_rs1_data    <= '0;
    i_instr_valid <= 1'b0;
    @(negedge i_clk);
    check_op_pc({t_name[last], " pc"}, t_pc[last], o_pc);
  endtask

  task automatic check_idle(input xlen_t pc_hold);
    for (int n = 0; n < IDLE_CYCLES; n++) begin
      @(posedge i_clk);
      // unstrobed csr swap with a real rd, then unstrobed ecall
      if (n % 2 == 0) begin
        i_instr <= csr_instr(F3_CSRRW, CSR_MSTATUS, 5'd1, 5'd11);
      end else begin
        i_instr <= 32'h0000_0073;
      end
      i_rs1_data <= 64'hffff_ffff_ffff_ffff;
      @(negedge i_clk);
      check_op_pc("idle pc", pc_hold, o_pc);
      check_bit("idle redirect", 1'b0, o_redirect);
      check_bit("idle rd_we", 1'b0, o_rd_we);
      check_data("idle rd_data", 64'h0, o_rd_data);
    end
  endtask

  initial begin
    i_instr       = '0;
    i_instr_valid = 1'b0;
    i_rs1_data    = '0;
    build_table();
    wait_reset_release();
    @(negedge i_clk);
    check_op_pc("reset pc", 64'h0000_0000_8000_0000, o_pc);
    check_bit("reset redirect", 1'b0, o_redirect);
    check_bit("reset rd_we", 1'b0, o_rd_we);
    run_table();
    check_idle(t_pc[t_pc.size()-1]);
    $display("Result: PASSED");
    $finish;
  end

endmodule

// ==== sources.f ====
source/sys_pkg.sv
source/sys_decoder.sv
source/csr_file.sv
source/pc_sequencer.sv
source/sys_unit_top.sv
dv/sys_unit_properties.sv
dv/sys_unit_tb.sv

// ==== Makefile ====
# Verilator build for the system unit

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns -j 0
TOP       ?= sys_unit_tb
FILELIST  ?= sources.f
OBJDIR    ?= obj_dir
PASS_MSG  := Result: PASSED

SIM_BIN := $(OBJDIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

$(SIM_BIN): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

# status comes from the search for the pass line
test: $(SIM_BIN)
	./$(SIM_BIN) | tee /dev/stderr | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)
